//--- src/cpu_config.svh
`ifndef CPU_CONFIG_SVH
`define CPU_CONFIG_SVH

`define WORD_SIZE 16            // data and address width
`define NUM_REGS  8             // r0..r7
`define REG_BITS  3             // register index width
`define RESET_PC  16'h0000      // first fetch address

// r7 reads as the program counter
`define PC_REG    3'd7

// operand select for the execute stage
`define FWD_REG   2'd0          // value read in decode
`define FWD_MEM   2'd1          // result sitting in the memory stage
`define FWD_WB    2'd2          // value being written back

`endif

//--- src/cpuPkg.sv
`include "cpu_config.svh"

package cpuPkg;

    // bits 15..13 of every instruction
    typedef enum logic [2:0] {
        opMv   = 3'd0,
        opMvtB = 3'd1,   // mvt when the immediate flag is set, branch otherwise
        opAdd  = 3'd2,
        opSub  = 3'd3,
        opLd   = 3'd4,
        opSt   = 3'd5,
        opAnd  = 3'd6,
        opHalt = 3'd7
    } opcodeType;

    typedef enum logic {memIdle, memBusy} memState;

    typedef struct packed {
        opcodeType              opcode;
        logic [`REG_BITS-1:0]   rX;
        logic [`REG_BITS-1:0]   rY;
        logic                   isImm;       // operand B comes from the immediate
        logic [`WORD_SIZE-1:0]  immediate;   // already extended
        logic                   regWrite;
        logic                   memRead;
        logic                   memWrite;
        logic                   isBranch;
        logic                   isMvt;
        logic                   isHalt;
    } decodedInstr;

    typedef struct packed {
        logic                   valid;
        decodedInstr            instr;
        logic [`WORD_SIZE-1:0]  pc;
        logic [`WORD_SIZE-1:0]  operandA;    // rX value, store data for st
        logic [`WORD_SIZE-1:0]  operandB;    // rY value or immediate
        logic [`WORD_SIZE-1:0]  result;      // raw instruction word in fetch/decode
    } pipeStage;

    typedef struct packed {
        logic                   cyc;
        logic                   stb;
        logic                   we;
        logic [`WORD_SIZE-1:0]  adr;
        logic [`WORD_SIZE-1:0]  dat;
    } wbRequest;

    typedef struct packed {
        logic                   ack;
        logic [`WORD_SIZE-1:0]  dat;
    } wbResponse;

endpackage

//--- src/registerFile.sv
`timescale 1ns/1ps
`include "cpu_config.svh"

module registerFile (
    input  logic                    Clock,
    input  logic                    Reset,
    input  logic [`REG_BITS-1:0]    readAddrA,
    input  logic [`REG_BITS-1:0]    readAddrB,
    output logic [`WORD_SIZE-1:0]   readDataA,
    output logic [`WORD_SIZE-1:0]   readDataB,
    input  logic                    writeEnable,
    input  logic [`REG_BITS-1:0]    writeAddr,
    input  logic [`WORD_SIZE-1:0]   writeData
);

    logic [`WORD_SIZE-1:0] regs [`NUM_REGS];

    always_ff @(posedge Clock or posedge Reset) begin
        if (Reset) begin
            for (int i = 0; i < `NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (writeEnable) begin
            regs[writeAddr] <= writeData;
        end
    end

    // a value written this cycle is seen by decode right away
    assign readDataA = (writeEnable && writeAddr == readAddrA) ? writeData : regs[readAddrA];
    assign readDataB = (writeEnable && writeAddr == readAddrB) ? writeData : regs[readAddrB];

    writeAddrKnown: assert property (@(posedge Clock) disable iff (Reset)
        writeEnable |-> !$isunknown(writeAddr))
        else $error("register write with unknown address");

endmodule

//--- src/decodeUnit.sv
`timescale 1ns/1ps
`include "cpu_config.svh"

module decodeUnit (
    input  logic [`WORD_SIZE-1:0]   instrWord,
    output cpuPkg::decodedInstr     decoded
);
    import cpuPkg::*;

    always_comb begin
        decoded = '0;
        decoded.opcode    = opcodeType'(instrWord[`WORD_SIZE-1 -: 3]);
        decoded.isImm     = instrWord[12];
        decoded.rX        = instrWord[11:9];
        decoded.rY        = instrWord[2:0];
        decoded.immediate = {{(`WORD_SIZE-9){1'b0}}, instrWord[8:0]};   // zero-extended

        case (decoded.opcode)
            opMvtB: begin
                if (instrWord[12]) begin
                    decoded.isMvt    = 1'b1;
                    decoded.regWrite = 1'b1;
                end else begin
                    // pc-relative offset, always taken
                    decoded.isBranch  = 1'b1;
                    decoded.isImm     = 1'b1;
                    decoded.immediate = {{(`WORD_SIZE-9){instrWord[8]}}, instrWord[8:0]};
                end
            end
            opLd: begin
                decoded.memRead  = 1'b1;
                decoded.regWrite = 1'b1;
            end
            opSt: begin
                decoded.memWrite = 1'b1;   // rX is the data, nothing written back
            end
            opHalt: begin
                decoded.isHalt = 1'b1;
            end
            default: begin
                decoded.regWrite = 1'b1;   // mv, add, sub, and
            end
        endcase

        // r7 is the pc and is not a writeback target
        if (decoded.rX == `PC_REG) begin
            decoded.regWrite = 1'b0;
        end
    end

endmodule

//--- src/hazardUnit.sv
`timescale 1ns/1ps
`include "cpu_config.svh"

module hazardUnit (
    input  cpuPkg::decodedInstr exInstr,
    input  cpuPkg::decodedInstr idInstr,
    input  logic                exValid,
    input  cpuPkg::decodedInstr memInstr,
    input  logic                memValid,
    input  logic                wbValid,
    input  cpuPkg::decodedInstr wbInstr,
    input  logic                memBusy,
    input  logic                branchTaken,
    output logic [1:0]          forwardA,
    output logic [1:0]          forwardB,
    output logic                stallFront,
    output logic                stallAll,
    output logic                flush
);

    logic memHitA, memHitB, wbHitA, wbHitB;
    logic idReadsLoad;

    assign memHitA = memValid && memInstr.regWrite && memInstr.rX == exInstr.rX;
    assign wbHitA  = wbValid && wbInstr.regWrite && wbInstr.rX == exInstr.rX;
    assign memHitB = memValid && memInstr.regWrite && memInstr.rX == exInstr.rY && !exInstr.isImm;
    assign wbHitB  = wbValid && wbInstr.regWrite && wbInstr.rX == exInstr.rY && !exInstr.isImm;

    // memory stage holds the younger producer, so it wins
    assign forwardA = memHitA ? `FWD_MEM : (wbHitA ? `FWD_WB : `FWD_REG);
    assign forwardB = memHitB ? `FWD_MEM : (wbHitB ? `FWD_WB : `FWD_REG);

    // conservative: rX counts as read even for mv and mvt
    assign idReadsLoad = exInstr.rX == idInstr.rX || (!idInstr.isImm && exInstr.rX == idInstr.rY);

    assign stallFront = exValid && exInstr.memRead && idReadsLoad;
    assign stallAll   = memBusy;
    assign flush      = branchTaken;

    // the core must hold a branch in execute while memory waits
    always_comb begin
        assert final (!(flush && stallAll))
            else $error("branch flush during a memory stall");
    end

endmodule

//--- src/memoryStage.sv
`timescale 1ns/1ps
`include "cpu_config.svh"

module memoryStage (
    input  logic                    Clock,
    input  logic                    Reset,
    input  logic                    start,
    input  logic                    isWrite,
    input  logic [`WORD_SIZE-1:0]   address,
    input  logic [`WORD_SIZE-1:0]   storeData,
    output cpuPkg::wbRequest        WbReq,
    input  cpuPkg::wbResponse       WbResp,
    output logic                    busy,
    output logic [`WORD_SIZE-1:0]   loadData
);
    import cpuPkg::*;

    memState state;
    logic [`WORD_SIZE-1:0] reqAdr, reqDat;
    logic reqWe;
    logic active;

    always_ff @(posedge Clock or posedge Reset) begin
        if (Reset) begin
            state <= memIdle;
            reqWe <= 1'b0;
        end else begin
            case (state)
                memIdle: if (start) begin
                    state <= memBusy;
                    reqWe <= isWrite;
                end
                memBusy: if (WbResp.ack) state <= memIdle;   // bus released next cycle
                default: state <= memIdle;
            endcase
        end
    end

    always_ff @(posedge Clock) begin
        if (state == memIdle && start) begin
            reqAdr <= address;
            reqDat <= storeData;
        end
        if (active && WbResp.ack && !reqWe) begin
            loadData <= WbResp.dat;
        end
    end

    assign active = state == memBusy;
    assign busy   = (state == memIdle && start) || (active && !WbResp.ack);

    assign WbReq = '{cyc: active, stb: active, we: active && reqWe, adr: reqAdr, dat: reqDat};

    reqHeldUntilAck: assert property (@(posedge Clock) disable iff (Reset)
        WbReq.stb && !WbResp.ack |=> WbReq.stb && $stable(WbReq.adr) && $stable(WbReq.we))
        else $error("wishbone request changed before ack");

    stbInsideCyc: assert property (@(posedge Clock) disable iff (Reset)
        WbReq.stb |-> WbReq.cyc)
        else $error("stb without cyc");

endmodule

//--- src/cpuCore.sv
`timescale 1ns/1ps
`include "cpu_config.svh"

module cpuCore (
    input  logic                    Clock,
    input  logic                    Reset,
    output logic [`WORD_SIZE-1:0]   InstrAddr,
    input  logic [`WORD_SIZE-1:0]   InstrIn,
    output cpuPkg::wbRequest        WbReq,
    input  cpuPkg::wbResponse       WbResp,
    output logic                    Halted
);
    import cpuPkg::*;

    logic [`WORD_SIZE-1:0] pc;
    pipeStage ifId, idEx, exMem, memWb;
    pipeStage fetchNext, idNext, exNext;
    decodedInstr decoded;
    logic [`WORD_SIZE-1:0] readDataA, readDataB, fwdA, fwdB, aluResult;
    logic [`WORD_SIZE-1:0] branchTarget, wbData, loadData;
    logic [1:0] forwardA, forwardB;
    logic stallFront, stallAll, flush, branchTaken, memBusy;
    logic fetchOff, haltInDecode, fetchGate;

    decodeUnit decoder (.instrWord(ifId.result), .decoded(decoded));

    registerFile regs (
        .Clock, .Reset,
        .readAddrA(decoded.rX), .readAddrB(decoded.rY),
        .readDataA, .readDataB,
        .writeEnable(memWb.valid && memWb.instr.regWrite),
        .writeAddr(memWb.instr.rX), .writeData(wbData)
    );

    hazardUnit hazards (
        .exInstr(idEx.instr), .idInstr(decoded), .exValid(idEx.valid),
        .memInstr(exMem.instr), .memValid(exMem.valid),
        .wbValid(memWb.valid), .wbInstr(memWb.instr),
        .memBusy, .branchTaken,
        .forwardA, .forwardB, .stallFront, .stallAll, .flush
    );

    memoryStage memStage (
        .Clock, .Reset,
        .start(exMem.valid && (exMem.instr.memRead || exMem.instr.memWrite)),
        .isWrite(exMem.instr.memWrite),
        .address(exMem.result), .storeData(exMem.operandA),
        .WbReq, .WbResp, .busy(memBusy), .loadData
    );

    assign InstrAddr    = pc;
    assign haltInDecode = ifId.valid && decoded.isHalt;
    assign fetchGate    = fetchOff || haltInDecode;    // nothing is fetched past a halt
    assign wbData       = memWb.instr.memRead ? loadData : memWb.result;
    assign branchTaken  = idEx.valid && idEx.instr.isBranch && !memBusy;
    assign branchTarget = idEx.pc + `WORD_SIZE'(1) + idEx.operandB;

    assign fwdA = (forwardA == `FWD_MEM) ? exMem.result :
                  (forwardA == `FWD_WB) ? wbData : idEx.operandA;
    assign fwdB = (forwardB == `FWD_MEM) ? exMem.result :
                  (forwardB == `FWD_WB) ? wbData : idEx.operandB;

    always_comb begin
        case (idEx.instr.opcode)
            opMv:       aluResult = fwdB;
            opMvtB:     aluResult = fwdB << 8;   // branch ignores it
            opAdd:      aluResult = fwdA + fwdB;
            opSub:      aluResult = fwdA - fwdB;
            opAnd:      aluResult = fwdA & fwdB;
            opLd, opSt: aluResult = fwdB;        // data address
            default:    aluResult = '0;
        endcase
    end

    always_comb begin
        fetchNext        = '0;
        fetchNext.valid  = !fetchGate;
        fetchNext.pc     = pc;
        fetchNext.result = InstrIn;

        idNext          = '0;
        idNext.valid    = ifId.valid;
        idNext.instr    = decoded;
        idNext.pc       = ifId.pc;
        idNext.operandA = (decoded.rX == `PC_REG) ? ifId.pc + `WORD_SIZE'(1) : readDataA;
        idNext.operandB = decoded.isImm ? decoded.immediate :
                          (decoded.rY == `PC_REG) ? ifId.pc + `WORD_SIZE'(1) : readDataB;

        exNext          = idEx;
        exNext.operandA = fwdA;
        exNext.operandB = fwdB;
        exNext.result   = aluResult;
    end

    always_ff @(posedge Clock or posedge Reset) begin
        if (Reset) begin
            pc       <= `RESET_PC;
            ifId     <= '0;
            idEx     <= '0;
            exMem    <= '0;
            memWb    <= '0;
            fetchOff <= 1'b0;
            Halted   <= 1'b0;
        end else begin
            memWb       <= exMem;
            memWb.valid <= exMem.valid && !stallAll;   // bubble while the bus waits
            if (stallAll) begin
                // keep forwarded values, the producer may leave writeback now
                idEx.operandA <= fwdA;
                idEx.operandB <= fwdB;
            end else begin
                exMem <= exNext;
                if (flush || stallFront) begin
                    idEx.valid <= 1'b0;
                end else begin
                    idEx <= idNext;
                end
                if (flush) begin
                    ifId.valid <= 1'b0;
                    pc         <= branchTarget;
                end else if (!stallFront) begin
                    ifId <= fetchNext;
                    if (!fetchGate) pc <= pc + `WORD_SIZE'(1);
                    if (haltInDecode) fetchOff <= 1'b1;
                end
            end
            if (memWb.valid && memWb.instr.isHalt) Halted <= 1'b1;
        end
    end

endmodule

//--- testbench/cpuChecker.sv
`timescale 1ns/1ps
`include "cpu_config.svh"

module cpuChecker (
    input  logic                    Clock,
    input  logic                    Reset,
    input  logic [`WORD_SIZE-1:0]   InstrAddr,
    input  cpuPkg::wbRequest        WbReq,
    input  cpuPkg::wbResponse       WbResp,
    input  logic                    Halted,
    output int                      errorCount,
    output int                      storesChecked,
    output logic                    done
);

    localparam int NumStores    = 7;
    localparam int StoreTimeout = 300;   // cycles per store

    logic [2*`WORD_SIZE-1:0] expected [NumStores];   // {adr, dat}
    int orderErrors = 0;
    int timeouts = 0;
    int busErrors = 0;
    int fetchErrors = 0;
    int writesTotal = 0;
    logic holding = 1'b0;
    logic busSeen = 1'b0;
    logic haltSeen = 1'b0;
    logic [`WORD_SIZE-1:0] heldAdr = '0;
    logic [`WORD_SIZE-1:0] haltAddr = '0;
    logic heldWe = 1'b0;
    logic writeAck;

    assign writeAck   = WbReq.cyc && WbReq.stb && WbReq.we && WbResp.ack;
    assign errorCount = orderErrors + timeouts + busErrors + fetchErrors;

    initial begin
        int waited;
        expected[0] = {16'd20, 16'h1234};
        expected[1] = {16'd20, 16'h0020};
        expected[2] = {16'd32, 16'h0014};
        expected[3] = {16'd40, 16'h13a9};   // preload 0x12a8 plus 0x101
        expected[4] = {16'd32, 16'h0020};
        expected[5] = {16'd40, 16'h0028};   // branch target, flushed stores skipped
        expected[6] = {16'd40, 16'h01fe};
        storesChecked = 0;
        done = 1'b0;
        for (int i = 0; i < NumStores && timeouts == 0; i++) begin
            waited = 0;
            @(negedge Clock);
            while (!writeAck && waited < StoreTimeout) begin
                @(negedge Clock);
                waited++;
            end
            if (writeAck) begin
                storesChecked++;
                if ({WbReq.adr, WbReq.dat} !== expected[i]) begin
                    orderErrors++;
                    $display("[ERROR] %0t store %0d wrote %h to %h, expected %h to %h", $time,
                             i, WbReq.dat, WbReq.adr, expected[i][15:0], expected[i][31:16]);
                end
            end else begin
                timeouts++;
                $display("no store %0d appeared on the bus within %0d cycles", i, StoreTimeout);
            end
        end
        done = 1'b1;
    end

    // bus protocol, fetch address and Halted, sampled away from the clock edge
    always @(negedge Clock) begin
        if (Reset) begin
            if (WbReq.cyc || WbReq.stb || Halted) begin
                busErrors++;
                $display("[ERROR] %0t cyc, stb or Halted high during reset", $time);
            end
            if (InstrAddr !== `RESET_PC) begin
                fetchErrors++;
                $display("[ERROR] %0t InstrAddr %h during reset, expected %h",
                         $time, InstrAddr, `RESET_PC);
            end
        end else begin
            if (holding && !(WbReq.stb && WbReq.adr == heldAdr && WbReq.we == heldWe)) begin
                busErrors++;
                $display("[ERROR] %0t request dropped or changed before ack", $time);
            end
            if (WbReq.stb && !WbReq.cyc) begin
                busErrors++;
                $display("[ERROR] %0t stb high without cyc", $time);
            end
            // the program's first memory access is a store
            if (!busSeen && WbReq.cyc && !WbReq.we) begin
                busErrors++;
                $display("[ERROR] %0t read cycle before the first store", $time);
            end
            if (Halted && (!busSeen || WbReq.cyc)) begin
                busErrors++;
                $display("[ERROR] %0t Halted high with cyc %b, bus used before %b",
                         $time, WbReq.cyc, busSeen);
            end
            if (haltSeen && !Halted) begin
                busErrors++;
                $display("[ERROR] %0t Halted fell after rising", $time);
            end
            if (haltSeen && InstrAddr !== haltAddr) begin
                fetchErrors++;
                $display("[ERROR] %0t InstrAddr moved to %h after halt, expected %h",
                         $time, InstrAddr, haltAddr);
            end
            if (writeAck) begin
                writesTotal++;
                if (writesTotal > NumStores) begin
                    busErrors++;
                    $display("[ERROR] %0t extra store of %h to %h", $time, WbReq.dat, WbReq.adr);
                end
            end
            if (Halted && !haltSeen) begin
                haltAddr = InstrAddr;   // fetch must stay here from now on
            end
            holding  = WbReq.stb && !WbResp.ack;
            heldAdr  = WbReq.adr;
            heldWe   = WbReq.we;
            busSeen  = busSeen || WbReq.cyc;
            haltSeen = haltSeen || Halted;
        end
    end

endmodule

//--- testbench/cpuTb.sv
`timescale 1ns/1ps
`include "cpu_config.svh"

module cpuTb;
    import cpuPkg::*;

    localparam int HaltTimeout = 1000;   // cycles
    localparam int DoneTimeout = 100;
    localparam int QuietCycles = 20;     // bus is watched this long after halt

    logic Clock;
    logic Reset;
    logic [`WORD_SIZE-1:0] InstrAddr;
    logic [`WORD_SIZE-1:0] InstrIn;
    wbRequest WbReq;
    wbResponse WbResp = '0;
    logic Halted;
    logic checkDone;
    int checkErrors;
    int storesChecked;
    int tbErrors;

    logic [`WORD_SIZE-1:0] rom [32];
    logic [`WORD_SIZE-1:0] dataMem [64];
    logic [15:0] lfsrState = 16'd31325;
    logic [1:0] waitLeft = '0;
    logic pending = 1'b0;

    cpuCore UUT (.Clock, .Reset, .InstrAddr, .InstrIn, .WbReq, .WbResp, .Halted);

    cpuChecker storeChecker (
        .Clock, .Reset, .InstrAddr, .WbReq, .WbResp, .Halted,
        .errorCount(checkErrors), .storesChecked, .done(checkDone)
    );

    // taps 16, 14, 13, 11
    function automatic logic [15:0] lfsrStep(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    function automatic logic [15:0] encode(input opcodeType op, input logic imm,
                                           input logic [2:0] rx, input logic [8:0] low);
        return {op, imm, rx, low};
    endfunction

    function automatic logic [15:0] fillWord(input int addr);
        return 16'h1000 + 16'(addr) * 16'h0011;
    endfunction

    assign InstrIn = rom[InstrAddr[4:0]];   // asynchronous instruction read

    initial begin
        Clock = 1'b0;
        forever #5 Clock = ~Clock;
    end

    // wishbone slave with 0 to 3 wait states per access
    always @(posedge Clock) begin
        logic [1:0] remaining;
        if (Reset) begin
            for (int i = 0; i < 64; i++) begin
                dataMem[i] <= fillWord(i);
            end
            WbResp  <= '0;
            pending <= 1'b0;
        end else if (WbResp.ack) begin
            WbResp.ack <= 1'b0;   // master drops the cycle now
            pending    <= 1'b0;
        end else if (WbReq.cyc && WbReq.stb) begin
            remaining = waitLeft;
            if (!pending) begin
                lfsrState    = lfsrStep(lfsrState);
                remaining[0] = lfsrState[0];
                lfsrState    = lfsrStep(lfsrState);
                remaining[1] = lfsrState[0];
            end
            pending <= 1'b1;
            if (remaining == 2'd0) begin
                WbResp.ack <= 1'b1;
                if (WbReq.we) begin
                    dataMem[WbReq.adr[5:0]] <= WbReq.dat;
                end else begin
                    WbResp.dat <= dataMem[WbReq.adr[5:0]];
                end
            end else begin
                waitLeft <= remaining - 2'd1;
            end
        end
    end

    initial begin
        int cycles;
        Reset    = 1'b1;
        tbErrors = 0;
        for (int a = 0; a < 32; a++) begin
            rom[a] = encode(opHalt, 1'b0, 3'd0, 9'd0);
        end
        rom[0]  = encode(opMvtB, 1'b1, 3'd1, 9'h012);   // r1 = 0x1200
        rom[1]  = encode(opAdd,  1'b1, 3'd1, 9'h034);   // r1 = 0x1234
        rom[2]  = encode(opMv,   1'b1, 3'd2, 9'd20);    // r2 = 20
        rom[3]  = encode(opSt,   1'b0, 3'd1, 9'd2);     // [20] = 0x1234
        rom[4]  = encode(opSub,  1'b0, 3'd1, 9'd2);     // r1 = 0x1220
        rom[5]  = encode(opAnd,  1'b1, 3'd1, 9'h0f0);   // r1 = 0x0020
        rom[6]  = encode(opSt,   1'b0, 3'd1, 9'd2);     // [20] = 0x0020
        rom[7]  = encode(opMv,   1'b0, 3'd3, 9'd1);     // r3 = r1
        rom[8]  = encode(opSt,   1'b0, 3'd2, 9'd3);     // [32] = 20
        rom[9]  = encode(opMv,   1'b1, 3'd4, 9'd40);    // r4 = 40
        rom[10] = encode(opLd,   1'b0, 3'd5, 9'd4);     // r5 = [40]
        rom[11] = encode(opAdd,  1'b1, 3'd5, 9'h101);   // load-use
        rom[12] = encode(opSt,   1'b0, 3'd5, 9'd4);
        rom[13] = encode(opLd,   1'b0, 3'd6, 9'd2);     // r6 = [20]
        rom[14] = encode(opSt,   1'b0, 3'd6, 9'd3);     // store right after load
        rom[15] = encode(opMvtB, 1'b0, 3'd0, 9'd2);     // branch to 18
        rom[16] = encode(opSt,   1'b0, 3'd4, 9'd2);     // flushed
        rom[17] = encode(opSt,   1'b0, 3'd5, 9'd2);     // flushed
        rom[18] = encode(opSt,   1'b0, 3'd4, 9'd4);     // branch target
        rom[19] = encode(opMv,   1'b1, 3'd1, 9'h1ff);
        rom[20] = encode(opSub,  1'b1, 3'd1, 9'd1);
        rom[21] = encode(opSt,   1'b0, 3'd1, 9'd4);
        rom[22] = encode(opHalt, 1'b0, 3'd0, 9'd0);

        repeat (16) @(posedge Clock);
        Reset <= 1'b0;

        cycles = 0;
        while (!Halted && cycles < HaltTimeout) begin
            @(posedge Clock);
            cycles++;
        end
        if (!Halted) begin
            $display("Halted did not rise within %0d cycles", HaltTimeout);
            tbErrors++;
        end
        cycles = 0;
        while (!checkDone && cycles < DoneTimeout) begin
            @(posedge Clock);
            cycles++;
        end
        if (!checkDone) begin
            $display("store checks did not finish within %0d cycles", DoneTimeout);
            tbErrors++;
        end
        repeat (QuietCycles) @(posedge Clock);

        $display("stores checked %0d, checker errors %0d, testbench errors %0d",
                 storesChecked, checkErrors, tbErrors);
        if (checkErrors == 0 && tbErrors == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

//--- verilog.f
+incdir+src
src/cpuPkg.sv
src/registerFile.sv
src/decodeUnit.sv
src/hazardUnit.sv
src/memoryStage.sv
src/cpuCore.sv
testbench/cpuChecker.sv
testbench/cpuTb.sv

//--- run.sh
#!/usr/bin/env bash
# build the core and testbench with Verilator, run, and check the log
set -u
cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary --timing --assert -Wno-fatal --top-module cpuTb \
    -f verilog.f --Mdir "$BUILD_DIR"
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

"./$BUILD_DIR/VcpuTb" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -qx ">>> PASS" "$LOG"; then
    exit 0
fi
exit 1
